// File: verilog/eth_udp_pkg.sv
package eth_udp_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [47:0] mac_t;
	typedef logic [31:0] ip4_t;
	typedef logic [15:0] port_t;
	typedef logic [10:0] len_t;	// 1 to 1024 payload bytes
	typedef logic [15:0] cmd_t;
	typedef logic [31:0] param_t;
	typedef logic [5:0]  hdr_idx_t;

	localparam int ETH_HDR_LEN = 14;
	localparam int IP_HDR_LEN  = 20;
	localparam int UDP_HDR_LEN = 8;
	localparam int HDR_LEN     = ETH_HDR_LEN + IP_HDR_LEN + UDP_HDR_LEN;

	localparam int    PREAMBLE_LEN  = 8;	// seven 55h then the SFD
	localparam byte_t PREAMBLE_BYTE = 8'h55;
	localparam byte_t SFD_BYTE      = 8'hd5;

	localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
	localparam byte_t       IP_PROTO_UDP   = 8'd17;
	localparam byte_t       IP_TTL         = 8'd128;

	// identifier and index bytes ahead of the payload
	localparam int PCK_HDR_LEN = 2;

	// command, complement, parameter
	localparam int CMD_LEN = 8;

	typedef enum logic [2:0]
	{
		TX_IDLE,
		TX_PREAMBLE,
		TX_HEADER,
		TX_PCK_ID,
		TX_PAYLOAD
	} tx_state_e;

	typedef enum logic [1:0]
	{
		RX_IDLE,
		RX_PREAMBLE,
		RX_STORE,
		RX_ERROR
	} rx_state_e;

	// fields picked out of a received command frame
	typedef struct packed
	{
		mac_t        dst_mac;
		logic [15:0] ethertype;
		byte_t       ip_proto;
		port_t       dst_port;
		cmd_t        cmd;
		logic [15:0] cmd_n;	// bitwise complement of cmd
		param_t      param;
	} rx_fields_t;

endpackage

// File: verilog/udp_hdr_gen.sv
`timescale 1ns/1ps

module udp_hdr_gen
#(
	parameter eth_udp_pkg::mac_t  LOCAL_MAC = 48'h02_00_00_00_00_04,
	parameter eth_udp_pkg::mac_t  DEST_MAC  = 48'h08_62_66_b3_84_1c,
	parameter eth_udp_pkg::ip4_t  LOCAL_IP  = 32'hc0_a8_01_04,
	parameter eth_udp_pkg::ip4_t  DEST_IP   = 32'hc0_a8_01_05,
	parameter eth_udp_pkg::port_t UDP_PORT  = 16'hfeef
)
(
	input  eth_udp_pkg::hdr_idx_t i_hdr_idx,
	input  eth_udp_pkg::len_t     i_data_length,
	output eth_udp_pkg::byte_t    o_hdr_byte
);

	localparam eth_udp_pkg::byte_t IP_VER_IHL = 8'h45;

	logic [15:0] ip_len;
	logic [15:0] udp_len;
	logic [19:0] csum_acc;
	logic [16:0] csum_fold;
	logic [15:0] ip_csum;
	logic [eth_udp_pkg::HDR_LEN*8-1:0] hdr;

	// both lengths count the two packet bytes ahead of the payload
	assign ip_len = 16'(i_data_length) + 16'(eth_udp_pkg::IP_HDR_LEN
		+ eth_udp_pkg::UDP_HDR_LEN + eth_udp_pkg::PCK_HDR_LEN);
	assign udp_len = 16'(i_data_length)
		+ 16'(eth_udp_pkg::UDP_HDR_LEN + eth_udp_pkg::PCK_HDR_LEN);

	// ones'-complement sum of the ten header words, checksum word as zero
	always_comb
	begin
		csum_acc = {4'h0, IP_VER_IHL, 8'h00}
			+ {4'h0, ip_len}
			+ {4'h0, eth_udp_pkg::IP_TTL, eth_udp_pkg::IP_PROTO_UDP}
			+ {4'h0, LOCAL_IP[31:16]}
			+ {4'h0, LOCAL_IP[15:0]}
			+ {4'h0, DEST_IP[31:16]}
			+ {4'h0, DEST_IP[15:0]};
		csum_fold = {1'b0, csum_acc[15:0]} + {13'h0, csum_acc[19:16]};
		ip_csum = ~(csum_fold[15:0] + {15'h0, csum_fold[16]});	// second fold
	end

	assign hdr =
	{
		DEST_MAC,
		LOCAL_MAC,
		eth_udp_pkg::ETHERTYPE_IPV4,
		IP_VER_IHL,
		8'h00,	// tos
		ip_len,
		16'h0000,	// identification
		16'h0000,	// flags, fragment offset
		eth_udp_pkg::IP_TTL,
		eth_udp_pkg::IP_PROTO_UDP,
		ip_csum,
		LOCAL_IP,
		DEST_IP,
		UDP_PORT,
		UDP_PORT,
		udp_len,
		16'h0000	// udp checksum unused
	};

	// byte 0 sits in the top octet
	always_comb
	begin
		if (int'(i_hdr_idx) < eth_udp_pkg::HDR_LEN)
			o_hdr_byte = hdr[8 * (eth_udp_pkg::HDR_LEN - 1 - int'(i_hdr_idx)) +: 8];
		else
			o_hdr_byte = '0;
	end

endmodule

// File: verilog/udp_tx_ctrl.sv
`timescale 1ns/1ps

module udp_tx_ctrl
(
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_trig_send,
	input  eth_udp_pkg::len_t     i_data_length,
	input  eth_udp_pkg::byte_t    i_pck_ident,
	input  eth_udp_pkg::byte_t    i_pck_idx,
	input  eth_udp_pkg::byte_t    i_cur_byte,
	output eth_udp_pkg::hdr_idx_t o_hdr_idx,
	output eth_udp_pkg::len_t     o_len,
	input  eth_udp_pkg::byte_t    i_hdr_byte,
	output logic                  o_feed_next_byte,
	output logic                  o_eth_txen,
	output eth_udp_pkg::byte_t    o_eth_txd,
	output logic                  o_send_over
);

	eth_udp_pkg::tx_state_e state, state_nx;
	eth_udp_pkg::len_t      cnt, cnt_nx;
	eth_udp_pkg::len_t      len_q;
	eth_udp_pkg::byte_t     tx_byte;
	logic                   trig_d;
	logic                   trig_edge;
	logic                   pend;
	logic                   start;
	logic                   txen_d;

	assign trig_edge = i_trig_send & ~trig_d;
	assign start = (state == eth_udp_pkg::TX_IDLE) && pend;
	assign o_hdr_idx = cnt[5:0];
	assign o_len = len_q;

	always_comb
	begin
		state_nx = state;
		cnt_nx = cnt + 1'b1;
		case (state)
			eth_udp_pkg::TX_IDLE:
			begin
				cnt_nx = '0;
				if (pend)
					state_nx = eth_udp_pkg::TX_PREAMBLE;
			end
			eth_udp_pkg::TX_PREAMBLE:
				if (cnt == eth_udp_pkg::len_t'(eth_udp_pkg::PREAMBLE_LEN - 1))
				begin
					state_nx = eth_udp_pkg::TX_HEADER;
					cnt_nx = '0;
				end
			eth_udp_pkg::TX_HEADER:
				if (cnt == eth_udp_pkg::len_t'(eth_udp_pkg::HDR_LEN - 1))
				begin
					state_nx = eth_udp_pkg::TX_PCK_ID;
					cnt_nx = '0;
				end
			eth_udp_pkg::TX_PCK_ID:
				if (cnt == eth_udp_pkg::len_t'(eth_udp_pkg::PCK_HDR_LEN - 1))
				begin
					state_nx = eth_udp_pkg::TX_PAYLOAD;
					cnt_nx = '0;
				end
			eth_udp_pkg::TX_PAYLOAD:
				if (cnt == len_q - 1'b1)
				begin
					state_nx = eth_udp_pkg::TX_IDLE;
					cnt_nx = '0;
				end
			default:
			begin
				state_nx = eth_udp_pkg::TX_IDLE;
				cnt_nx = '0;
			end
		endcase
	end

	// byte for the current state, registered onto the wire
	always_comb
	begin
		case (state)
			eth_udp_pkg::TX_PREAMBLE:
				tx_byte = (cnt == eth_udp_pkg::len_t'(eth_udp_pkg::PREAMBLE_LEN - 1)) ?
					eth_udp_pkg::SFD_BYTE : eth_udp_pkg::PREAMBLE_BYTE;
			eth_udp_pkg::TX_HEADER:  tx_byte = i_hdr_byte;
			eth_udp_pkg::TX_PCK_ID:  tx_byte = cnt[0] ? i_pck_idx : i_pck_ident;
			eth_udp_pkg::TX_PAYLOAD: tx_byte = i_cur_byte;
			default:                 tx_byte = '0;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state <= eth_udp_pkg::TX_IDLE;
			cnt <= '0;
			len_q <= '0;
			trig_d <= 1'b0;
			pend <= 1'b0;
			txen_d <= 1'b0;
			o_eth_txen <= 1'b0;
			o_feed_next_byte <= 1'b0;
			o_send_over <= 1'b0;
		end
		else
		begin
			state <= state_nx;
			cnt <= cnt_nx;
			trig_d <= i_trig_send;
			if (start)
			begin
				len_q <= i_data_length;
				pend <= trig_edge;	// an edge right at start is kept for the next frame
			end
			else if (trig_edge)
				pend <= 1'b1;
			o_eth_txen <= (state != eth_udp_pkg::TX_IDLE);
			o_feed_next_byte <= (state_nx == eth_udp_pkg::TX_PAYLOAD);
			txen_d <= o_eth_txen;
			o_send_over <= txen_d & ~o_eth_txen;	// cycle after txen drops
		end
	end

	always_ff @(posedge i_clk)
		o_eth_txd <= tx_byte;

endmodule

// File: verilog/eth_rx_capture.sv
`timescale 1ns/1ps

module eth_rx_capture
(
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  logic                    i_eth_rxdv,
	input  eth_udp_pkg::byte_t      i_eth_rxd,
	output eth_udp_pkg::rx_fields_t o_fields,
	output logic                    o_frame_done
);

	// offsets counted from the first byte after the SFD
	localparam int OFS_DST_MAC = 0;
	localparam int OFS_ETYPE   = 12;
	localparam int OFS_PROTO   = 23;
	localparam int OFS_PORT    = 36;
	localparam int OFS_CMD     = eth_udp_pkg::HDR_LEN;
	localparam int FRAME_LEN   = eth_udp_pkg::HDR_LEN + eth_udp_pkg::CMD_LEN;

	eth_udp_pkg::rx_state_e state;
	logic [2:0] pre_cnt;
	logic [5:0] idx;	// saturates at FRAME_LEN

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state <= eth_udp_pkg::RX_IDLE;
			pre_cnt <= '0;
			idx <= '0;
			o_frame_done <= 1'b0;
		end
		else
		begin
			o_frame_done <= 1'b0;
			case (state)
				eth_udp_pkg::RX_IDLE:
					if (i_eth_rxdv)
					begin
						pre_cnt <= 3'd1;
						idx <= '0;
						if (i_eth_rxd == eth_udp_pkg::PREAMBLE_BYTE)
							state <= eth_udp_pkg::RX_PREAMBLE;
						else
							state <= eth_udp_pkg::RX_ERROR;
					end
				eth_udp_pkg::RX_PREAMBLE:
				begin
					pre_cnt <= pre_cnt + 1'b1;
					if (!i_eth_rxdv)
						state <= eth_udp_pkg::RX_IDLE;	// frame ended inside preamble
					else if (pre_cnt == 3'(eth_udp_pkg::PREAMBLE_LEN - 1))
					begin
						if (i_eth_rxd == eth_udp_pkg::SFD_BYTE)
							state <= eth_udp_pkg::RX_STORE;
						else
							state <= eth_udp_pkg::RX_ERROR;
					end
					else if (i_eth_rxd != eth_udp_pkg::PREAMBLE_BYTE)
						state <= eth_udp_pkg::RX_ERROR;
				end
				eth_udp_pkg::RX_STORE:
				begin
					if (!i_eth_rxdv)
					begin
						o_frame_done <= (idx == 6'(FRAME_LEN));
						state <= eth_udp_pkg::RX_IDLE;
					end
					else if (idx != 6'(FRAME_LEN))
						idx <= idx + 1'b1;
				end
				eth_udp_pkg::RX_ERROR:
					if (!i_eth_rxdv)
						state <= eth_udp_pkg::RX_IDLE;
				default:
					state <= eth_udp_pkg::RX_IDLE;
			endcase
		end
	end

	// multi-byte fields shift in msb first
	always_ff @(posedge i_clk)
	begin
		if (state == eth_udp_pkg::RX_STORE && i_eth_rxdv)
		begin
			case (int'(idx)) inside
				[OFS_DST_MAC:OFS_DST_MAC+5]:
					o_fields.dst_mac <= {o_fields.dst_mac[39:0], i_eth_rxd};
				[OFS_ETYPE:OFS_ETYPE+1]:
					o_fields.ethertype <= {o_fields.ethertype[7:0], i_eth_rxd};
				OFS_PROTO:
					o_fields.ip_proto <= i_eth_rxd;
				[OFS_PORT:OFS_PORT+1]:
					o_fields.dst_port <= {o_fields.dst_port[7:0], i_eth_rxd};
				[OFS_CMD:OFS_CMD+1]:
					o_fields.cmd <= {o_fields.cmd[7:0], i_eth_rxd};
				[OFS_CMD+2:OFS_CMD+3]:
					o_fields.cmd_n <= {o_fields.cmd_n[7:0], i_eth_rxd};
				[OFS_CMD+4:OFS_CMD+7]:
					o_fields.param <= {o_fields.param[23:0], i_eth_rxd};
				default:
					o_fields <= o_fields;
			endcase
		end
	end

endmodule

// File: verilog/cmd_decode.sv
`timescale 1ns/1ps

module cmd_decode
#(
	parameter eth_udp_pkg::mac_t  LOCAL_MAC = 48'h02_00_00_00_00_04,
	parameter eth_udp_pkg::port_t UDP_PORT  = 16'hfeef
)
(
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  eth_udp_pkg::rx_fields_t i_fields,
	input  logic                    i_frame_done,
	output eth_udp_pkg::cmd_t       o_cmd,
	output eth_udp_pkg::param_t     o_param,
	output logic                    o_cmd_come
);

	logic mac_ok;
	logic proto_ok;
	logic port_ok;
	logic check_ok;
	logic accept;

	// own address or broadcast
	assign mac_ok = (i_fields.dst_mac == LOCAL_MAC) || (&i_fields.dst_mac);
	assign proto_ok = (i_fields.ethertype == eth_udp_pkg::ETHERTYPE_IPV4)
		&& (i_fields.ip_proto == eth_udp_pkg::IP_PROTO_UDP);
	assign port_ok = (i_fields.dst_port == UDP_PORT);
	assign check_ok = (i_fields.cmd_n == ~i_fields.cmd);
	assign accept = mac_ok && proto_ok && port_ok && check_ok;

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_cmd <= '0;
			o_param <= '0;
			o_cmd_come <= 1'b0;
		end
		else
		begin
			o_cmd_come <= i_frame_done && accept;	// one-cycle strobe
			if (i_frame_done && accept)
			begin
				o_cmd <= i_fields.cmd;
				o_param <= i_fields.param;
			end
		end
	end

endmodule

// File: verilog/eth_commu.sv
`timescale 1ns/1ps

module eth_commu
#(
	parameter eth_udp_pkg::mac_t  LOCAL_MAC = 48'h02_00_00_00_00_04,
	parameter eth_udp_pkg::mac_t  DEST_MAC  = 48'h08_62_66_b3_84_1c,
	parameter eth_udp_pkg::ip4_t  LOCAL_IP  = 32'hc0_a8_01_04,
	parameter eth_udp_pkg::ip4_t  DEST_IP   = 32'hc0_a8_01_05,
	parameter eth_udp_pkg::port_t UDP_PORT  = 16'hfeef
)
(
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  logic                i_trig_send,
	input  eth_udp_pkg::len_t   i_data_length,
	input  eth_udp_pkg::byte_t  i_pck_ident,
	input  eth_udp_pkg::byte_t  i_pck_idx,
	input  eth_udp_pkg::byte_t  i_cur_byte,
	input  logic                i_eth_rxdv,
	input  eth_udp_pkg::byte_t  i_eth_rxd,
	output logic                o_feed_next_byte,
	output logic                o_send_over,
	output logic                o_eth_txen,
	output eth_udp_pkg::byte_t  o_eth_txd,
	output eth_udp_pkg::cmd_t   o_cmd,
	output eth_udp_pkg::param_t o_param,
	output logic                o_cmd_come
);

	eth_udp_pkg::hdr_idx_t   hdr_idx;
	eth_udp_pkg::byte_t      hdr_byte;
	eth_udp_pkg::len_t       tx_len;
	eth_udp_pkg::rx_fields_t rx_fields;
	logic                    rx_frame_done;

	udp_tx_ctrl u_tx_ctrl
	(
		.i_clk            (i_clk),
		.i_rst_n          (i_rst_n),
		.i_trig_send      (i_trig_send),
		.i_data_length    (i_data_length),
		.i_pck_ident      (i_pck_ident),
		.i_pck_idx        (i_pck_idx),
		.i_cur_byte       (i_cur_byte),
		.o_hdr_idx        (hdr_idx),
		.o_len            (tx_len),
		.i_hdr_byte       (hdr_byte),
		.o_feed_next_byte (o_feed_next_byte),
		.o_eth_txen       (o_eth_txen),
		.o_eth_txd        (o_eth_txd),
		.o_send_over      (o_send_over)
	);

	udp_hdr_gen
	#(
		.LOCAL_MAC (LOCAL_MAC),
		.DEST_MAC  (DEST_MAC),
		.LOCAL_IP  (LOCAL_IP),
		.DEST_IP   (DEST_IP),
		.UDP_PORT  (UDP_PORT)
	) u_hdr_gen
	(
		.i_hdr_idx     (hdr_idx),
		.i_data_length (tx_len),
		.o_hdr_byte    (hdr_byte)
	);

	eth_rx_capture u_rx_capture
	(
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_eth_rxdv   (i_eth_rxdv),
		.i_eth_rxd    (i_eth_rxd),
		.o_fields     (rx_fields),
		.o_frame_done (rx_frame_done)
	);

	cmd_decode
	#(
		.LOCAL_MAC (LOCAL_MAC),
		.UDP_PORT  (UDP_PORT)
	) u_cmd_decode
	(
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_fields     (rx_fields),
		.i_frame_done (rx_frame_done),
		.o_cmd        (o_cmd),
		.o_param      (o_param),
		.o_cmd_come   (o_cmd_come)
	);

endmodule

// File: tb/tb_eth_commu_properties.sv
`timescale 1ns/1ps

module tb_eth_commu_properties
(
	input logic i_clk,
	input logic i_rst_n,
	input logic o_feed_next_byte,
	input logic o_send_over,
	input logic o_eth_txen,
	input logic o_cmd_come
);

	int fail_cnt = 0;	// failed assertions so far

	a_send_over_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_send_over |=> !o_send_over)
	else
	begin
		$error("o_send_over high for more than one cycle");
		fail_cnt++;
	end

	a_cmd_come_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_cmd_come |=> !o_cmd_come)
	else
	begin
		$error("o_cmd_come high for more than one cycle");
		fail_cnt++;
	end

	// payload bytes only go out inside a frame
	a_feed_in_frame: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_feed_next_byte |-> o_eth_txen)
	else
	begin
		$error("o_feed_next_byte high while o_eth_txen is low");
		fail_cnt++;
	end

	a_over_after_fall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$fell(o_eth_txen) |=> o_send_over)
	else
	begin
		$error("o_send_over missing one cycle after o_eth_txen fell");
		fail_cnt++;
	end

endmodule

bind eth_commu tb_eth_commu_properties u_props
(
	.i_clk            (i_clk),
	.i_rst_n          (i_rst_n),
	.o_feed_next_byte (o_feed_next_byte),
	.o_send_over      (o_send_over),
	.o_eth_txen       (o_eth_txen),
	.o_cmd_come       (o_cmd_come)
);

// File: tb/tb_eth_commu.sv
`timescale 1ns/1ps

module tb_eth_commu;

	localparam eth_udp_pkg::mac_t  LOCAL_MAC = 48'h02_00_00_00_00_04;
	localparam eth_udp_pkg::mac_t  DEST_MAC  = 48'h08_62_66_b3_84_1c;
	localparam eth_udp_pkg::ip4_t  LOCAL_IP  = 32'hc0_a8_01_04;
	localparam eth_udp_pkg::ip4_t  DEST_IP   = 32'hc0_a8_01_05;
	localparam eth_udp_pkg::port_t UDP_PORT  = 16'hfeef;

	localparam int NUM_TESTS = 14;	// four send sequences, ten command frames
	localparam int RX_WAIT   = 5;	// strobe window after rxdv falls

	logic                i_clk = 1'b0;
	logic                i_rst_n;
	logic                trig_send;
	eth_udp_pkg::len_t   data_length;
	eth_udp_pkg::byte_t  pck_ident;
	eth_udp_pkg::byte_t  pck_idx;
	eth_udp_pkg::byte_t  cur_byte = 8'h00;
	logic                eth_rxdv;
	eth_udp_pkg::byte_t  eth_rxd;
	logic                feed_next_byte;
	logic                send_over;
	logic                eth_txen;
	eth_udp_pkg::byte_t  eth_txd;
	eth_udp_pkg::cmd_t   cmd;
	eth_udp_pkg::param_t param;
	logic                cmd_come;

	logic [31:0]         lfsr = 32'hd2b5_13b9;
	eth_udp_pkg::byte_t  feed_q[$];	// payload bytes still owed to the DUT
	eth_udp_pkg::byte_t  exp_q[$];
	int                  exp_len_q[$];
	eth_udp_pkg::byte_t  exp_b;
	int                  exp_len;
	eth_udp_pkg::cmd_t   exp_cmd = '0;
	eth_udp_pkg::param_t exp_param = '0;
	logic                txen_q = 1'b0;
	int                  run_len = 0;
	int                  feed_cnt = 0;
	int                  over_cnt = 0;
	int                  come_cnt = 0;
	int                  exp_come = 0;
	int                  frames_sent = 0;
	int                  frames_seen = 0;
	int                  tx_err = 0;
	int                  field_err = 0;
	int                  misc_err = 0;

	eth_commu dut0
	(
		.i_clk            (i_clk),
		.i_rst_n          (i_rst_n),
		.i_trig_send      (trig_send),
		.i_data_length    (data_length),
		.i_pck_ident      (pck_ident),
		.i_pck_idx        (pck_idx),
		.i_cur_byte       (cur_byte),
		.i_eth_rxdv       (eth_rxdv),
		.i_eth_rxd        (eth_rxd),
		.o_feed_next_byte (feed_next_byte),
		.o_send_over      (send_over),
		.o_eth_txen       (eth_txen),
		.o_eth_txd        (eth_txd),
		.o_cmd            (cmd),
		.o_param          (param),
		.o_cmd_come       (cmd_come)
	);

	always #50 i_clk = ~i_clk;

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic lfsr_bit();
		lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
		return lfsr[0];
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	// ones'-complement sum of the ten ip words with the checksum word as zero
	function automatic logic [15:0] ip_checksum(input int n);
		logic [31:0] sum;
		sum = 32'h4500 + 32'(n + 30) + 32'h8011
			+ 32'(LOCAL_IP[31:16]) + 32'(LOCAL_IP[15:0])
			+ 32'(DEST_IP[31:16]) + 32'(DEST_IP[15:0]);
		while (sum[31:16] != 16'h0)
			sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
		return ~sum[15:0];
	endfunction

	function automatic logic [335:0] header_bits(input eth_udp_pkg::mac_t dst,
		input eth_udp_pkg::mac_t src, input int n, input eth_udp_pkg::byte_t proto,
		input eth_udp_pkg::port_t dport);
		return {dst, src, 16'h0800, 16'h4500, 16'(n + 30), 32'h0, 8'd128, proto,
			ip_checksum(n), LOCAL_IP, DEST_IP, UDP_PORT, dport, 16'(n + 10), 16'h0};
	endfunction

	task automatic check_field(input string name, input logic [47:0] got,
		input logic [47:0] exp);
		if (got !== exp)
		begin
			$display("[ERROR] %0t %s expected %0h got %0h", $time, name, exp, got);
			field_err++;
		end
	endtask

	// queues the expected wire bytes of one frame and its payload for the feeder
	task automatic expect_frame(input int n, input eth_udp_pkg::byte_t id,
		input eth_udp_pkg::byte_t ix);
		logic [335:0] h;
		eth_udp_pkg::byte_t b;
		h = header_bits(DEST_MAC, LOCAL_MAC, n, 8'd17, UDP_PORT);
		for (int i = 0; i < 8; i++)
			exp_q.push_back((i == 7) ? 8'hd5 : 8'h55);
		for (int i = 41; i >= 0; i--)
			exp_q.push_back(h[i*8 +: 8]);
		exp_q.push_back(id);
		exp_q.push_back(ix);
		for (int i = 0; i < n; i++)
		begin
			b = 8'(rand_bits(8));
			feed_q.push_back(b);
			exp_q.push_back(b);
		end
		exp_len_q.push_back(52 + n);
		frames_sent++;
	endtask

	// count 2 puts a second trigger edge in the middle of the first frame
	task automatic send_frames(input int count);
		int n;
		int seen;
		int waited;
		eth_udp_pkg::byte_t id;
		eth_udp_pkg::byte_t ix;
		n = int'(rand_bits(6)) + 1;
		id = 8'(rand_bits(8));
		ix = 8'(rand_bits(8));
		@(posedge i_clk);
		data_length <= eth_udp_pkg::len_t'(n);
		pck_ident <= id;
		pck_idx <= ix;
		expect_frame(n, id, ix);
		@(posedge i_clk);
		trig_send <= 1'b1;
		@(posedge i_clk);
		trig_send <= 1'b0;
		if (count == 2)
		begin
			repeat (20) @(posedge i_clk);
			expect_frame(n, id, ix);
			trig_send <= 1'b1;
			@(posedge i_clk);
			trig_send <= 1'b0;
		end
		seen = 0;
		waited = 0;
		while (seen < count && waited < 2 * 1180)
		begin
			@(posedge i_clk);
			waited++;
			if (send_over)
				seen++;
		end
		if (seen < count)
		begin
			$display("%0t: o_send_over never came after a triggered frame", $time);
			misc_err++;
		end
		repeat (4) @(posedge i_clk);
	endtask

	// kind 0 own mac, 1 broadcast, 2 wrong mac, 3 wrong port, 4 wrong protocol,
	// 5 bad complement, 6 bad preamble, 7 one byte short
	task automatic send_command(input int kind);
		logic [335:0] h;
		eth_udp_pkg::byte_t fq[$];
		eth_udp_pkg::mac_t dst;
		eth_udp_pkg::port_t dport;
		eth_udp_pkg::byte_t proto;
		eth_udp_pkg::cmd_t c;
		eth_udp_pkg::param_t p;
		logic [15:0] c_n;
		logic accept;
		int seen;
		c = 16'(rand_bits(16));
		p = rand_bits(32);
		c_n = (kind == 5) ? (~c ^ 16'h0100) : ~c;
		dst = (kind == 1) ? '1 : LOCAL_MAC;
		if (kind == 2)
			dst = LOCAL_MAC ^ 48'(rand_bits(32) | 32'h1);
		dport = (kind == 3) ? (UDP_PORT + 16'h1) : UDP_PORT;
		proto = (kind == 4) ? 8'd6 : 8'd17;
		accept = (dst == LOCAL_MAC || dst == '1) && proto == 8'd17
			&& dport == UDP_PORT && c_n == ~c && kind != 6 && kind != 7;
		h = header_bits(dst, DEST_MAC, 8, proto, dport);
		for (int i = 0; i < 8; i++)
			fq.push_back((i == 7) ? 8'hd5 : 8'h55);
		if (kind == 6)
			fq[3] = 8'h5d;
		for (int i = 41; i >= 0; i--)
			fq.push_back(h[i*8 +: 8]);
		fq.push_back(c[15:8]);
		fq.push_back(c[7:0]);
		fq.push_back(c_n[15:8]);
		fq.push_back(c_n[7:0]);
		for (int i = 3; i >= 0; i--)
			fq.push_back(p[i*8 +: 8]);
		if (kind == 7)
			void'(fq.pop_back());
		foreach (fq[i])
		begin
			@(posedge i_clk);
			eth_rxdv <= 1'b1;
			eth_rxd <= fq[i];
		end
		@(posedge i_clk);
		eth_rxdv <= 1'b0;
		eth_rxd <= '0;
		seen = 0;
		repeat (RX_WAIT)
		begin
			@(posedge i_clk);
			if (cmd_come)
				seen++;
		end
		if (accept)
		begin
			exp_cmd = c;
			exp_param = p;
			exp_come++;
		end
		check_field("o_cmd_come", 48'(seen), accept ? 48'd1 : 48'd0);
		check_field("o_cmd", 48'(cmd), 48'(exp_cmd));
		check_field("o_param", 48'(param), 48'(exp_param));
		repeat (3) @(posedge i_clk);
	endtask

	// payload feeder presents the next byte from the consuming edge on
	always @(posedge i_clk)
	begin
		if (feed_next_byte && feed_q.size() > 0)
			void'(feed_q.pop_front());
		cur_byte <= (feed_q.size() > 0) ? feed_q[0] : 8'h00;
	end

	// wire monitor
	always @(posedge i_clk)
	begin
		if (eth_txen)
		begin
			if (exp_q.size() == 0)
			begin
				$display("%0t: byte on the wire while no frame was expected", $time);
				misc_err++;
			end
			else
			begin
				exp_b = exp_q.pop_front();
				if (eth_txd !== exp_b)
				begin
					$display("[ERROR] %0t o_eth_txd byte %0d expected %02h got %02h",
						$time, run_len, exp_b, eth_txd);
					tx_err++;
				end
			end
			run_len++;
		end
		if (feed_next_byte)
			feed_cnt++;
		if (txen_q && !eth_txen)
		begin
			exp_len = (exp_len_q.size() > 0) ? exp_len_q.pop_front() : 0;
			if (run_len != exp_len)
			begin
				$display("[ERROR] %0t o_eth_txen cycles expected %0d got %0d",
					$time, exp_len, run_len);
				tx_err++;
			end
			if (feed_cnt != exp_len - 52)
			begin
				$display("[ERROR] %0t o_feed_next_byte cycles expected %0d got %0d",
					$time, exp_len - 52, feed_cnt);
				tx_err++;
			end
			run_len = 0;
			feed_cnt = 0;
			frames_seen++;
		end
		if (send_over)
			over_cnt++;
		if (cmd_come)
			come_cnt++;
		txen_q = eth_txen;
	end

	initial
	begin
		i_rst_n = 1'b0;
		trig_send = 1'b0;
		data_length = '0;
		pck_ident = '0;
		pck_idx = '0;
		eth_rxdv = 1'b0;
		eth_rxd = '0;
		repeat (16) @(posedge i_clk);
		check_field("o_eth_txen", 48'(eth_txen), 48'd0);
		check_field("o_feed_next_byte", 48'(feed_next_byte), 48'd0);
		check_field("o_send_over", 48'(send_over), 48'd0);
		check_field("o_cmd_come", 48'(cmd_come), 48'd0);
		check_field("o_cmd", 48'(cmd), 48'd0);
		check_field("o_param", 48'(param), 48'd0);
		i_rst_n <= 1'b1;
		repeat (4) @(posedge i_clk);
		repeat (3) send_frames(1);
		send_frames(2);
		for (int k = 0; k < 8; k++)
			send_command(k);
		send_command(0);
		send_command(1);
		repeat (10) @(posedge i_clk);
		if (exp_q.size() != 0 || frames_seen != frames_sent)
		begin
			$display("%0t: %0d of %0d frames seen on the wire", $time, frames_seen,
				frames_sent);
			misc_err++;
		end
		check_field("o_send_over pulses", 48'(over_cnt), 48'(frames_sent));
		check_field("o_cmd_come pulses", 48'(come_cnt), 48'(exp_come));
		$display("errors: tx %0d fields %0d other %0d assertions %0d", tx_err, field_err,
			misc_err, dut0.u_props.fail_cnt);
		if (tx_err + field_err + misc_err + dut0.u_props.fail_cnt == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	initial
	begin
		#(NUM_TESTS * (1100 + 80) * 100 * 2);
		$display("watchdog: the run did not finish in time");
		$display(">>> FAIL");
		$finish;
	end

endmodule

// File: eth_commu.f
verilog/eth_udp_pkg.sv
verilog/udp_hdr_gen.sv
verilog/udp_tx_ctrl.sv
verilog/eth_rx_capture.sv
verilog/cmd_decode.sv
verilog/eth_commu.sv
tb/tb_eth_commu_properties.sv
tb/tb_eth_commu.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_eth_commu \
	-f eth_commu.f -o sim_eth_commu

status=0
./obj_dir/sim_eth_commu +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q ">>> FAIL" sim.log; then
	echo "simulation failed"
	exit 1
fi
[ "$status" -eq 0 ]
echo "simulation passed"
